/* hw/pce_pad_pkg.sv */
// ========================================
// Controller port definitions
// Widths, the port word and reset values
// shared by the pad input blocks
// ========================================

package pce_pad_pkg;

	// Four directions, four buttons, four extra buttons
	localparam int joy_w = 12;

	// Multitap ports; anything at or above reads as empty
	localparam int num_ports = 5;

	typedef logic [2:0] port_idx_t;   // Multitap port number
	typedef logic [1:0] nibble_idx_t; // Mouse nibble counter

	// ========================================
	// Port word, as the core sees it
	// ========================================
	// pad view, nibble 3 down to 0:
	//   3 unused, always 0
	//   2 extra buttons III..VI, inverted
	//   1 left, down, right, up, inverted
	//   0 run, select, II, I, inverted
	// mouse view: the same mouse byte twice
	typedef union packed {
		logic [3:0][3:0] pad;
		logic [1:0][7:0] mouse;
	} pad_word_u;

	// Nothing plugged into this port
	localparam pad_word_u empty_word = 16'h0FFF;

	// Values taken on reset
	localparam port_idx_t   port_rst = 3'd0;
	localparam nibble_idx_t nib_rst  = 2'd3;  // Next frame starts at x high

endpackage

/* hw/pad_port_ctrl.sv */
// ========================================
// Controller port sequencer
// Turns sel/clr edges into multitap port,
// six-button bank and mouse nibble state
// ========================================

`timescale 1ns/1ps

module pad_port_ctrl #(
	parameter int mouse_timeout_w = 15
) (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic [1:0]               joy_out,    // bit 0 sel, bit 1 clr
	input  logic                     turbotap,
	input  logic                     buttons6,
	output pce_pad_pkg::port_idx_t   port,
	output logic                     high_bank,
	output pce_pad_pkg::nibble_idx_t nib_cnt,
	output logic                     frame_wrap
);

	logic [1:0]                 joy_out_q;  // Last sampled strobes
	logic [mouse_timeout_w-1:0] idle_cnt;
	logic                       sel;
	logic                       clr;
	logic                       sel_rise;
	logic                       clr_rise;
	logic                       idle_sat;

	assign sel = joy_out[0];
	assign clr = joy_out[1];

	assign sel_rise = sel & ~joy_out_q[0];
	assign clr_rise = clr & ~joy_out_q[1];
	assign idle_sat = &idle_cnt;

	// Deltas move over once the last nibble of a frame is done
	assign frame_wrap = clr_rise & (nib_cnt == 2'd3);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			joy_out_q <= 2'b00;
		end else begin
			joy_out_q <= joy_out;
		end
	end

	// ========================================
	// Multitap scan and six-button bank
	// ========================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			port      <= pce_pad_pkg::port_rst;
			high_bank <= 1'b0;
		end else if (clr) begin
			port <= pce_pad_pkg::port_rst;
			if (clr_rise)
				high_bank <= ~high_bank & buttons6;  // Toggles once per clr frame
		end else if (sel_rise && turbotap) begin
			port <= port + 3'd1;
		end
	end

	// ========================================
	// Mouse nibble count and idle timeout
	// ========================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			idle_cnt <= '0;
		end else if (clr) begin
			idle_cnt <= '0;
		end else if (!idle_sat) begin
			idle_cnt <= idle_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			nib_cnt <= pce_pad_pkg::nib_rst;
		end else if (clr_rise) begin
			nib_cnt <= nib_cnt + 2'd1;
		end else if (idle_sat) begin
			nib_cnt <= pce_pad_pkg::nib_rst;  // Host went quiet so resync
		end
	end

	// After the host went quiet the next clr starts a fresh mouse frame
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		clr_rise && $past(idle_sat) |-> frame_wrap)
		else $error("clr after idle timeout did not wrap the mouse frame");

endmodule

/* hw/pad_word_mapper.sv */
// ========================================
// Port word mapper
// Swaps and selects the joystick for the
// current port, builds the port word
// ========================================

`timescale 1ns/1ps

module pad_word_mapper (
	input  logic [pce_pad_pkg::joy_w-1:0] joy_a,
	input  logic [pce_pad_pkg::joy_w-1:0] joy_b,
	input  logic [pce_pad_pkg::joy_w-1:0] joy_2,
	input  logic [pce_pad_pkg::joy_w-1:0] joy_3,
	input  logic [pce_pad_pkg::joy_w-1:0] joy_4,
	input  logic                          joy_swap,
	input  logic                          mouse_en,
	input  pce_pad_pkg::port_idx_t        port,
	input  logic [7:0]                    mouse_byte,
	output pce_pad_pkg::pad_word_u        word,
	output logic [1:0]                    pad0_run_select
);

	logic [pce_pad_pkg::joy_w-1:0] joy_0;
	logic [pce_pad_pkg::joy_w-1:0] joy_1;
	logic [pce_pad_pkg::joy_w-1:0] joy_sel;

	// Active-low pad word from one joystick
	function automatic pce_pad_pkg::pad_word_u pad_view(
		input logic [pce_pad_pkg::joy_w-1:0] j
	);
		pce_pad_pkg::pad_word_u w;
		w.pad[3] = 4'h0;
		w.pad[2] = ~j[11:8];                   // III..VI
		w.pad[1] = ~{j[1], j[2], j[0], j[3]};  // Left, down, right, up
		w.pad[0] = ~j[7:4];                    // Run, select, II, I
		return w;
	endfunction

	assign joy_0 = joy_swap ? joy_b : joy_a;
	assign joy_1 = joy_swap ? joy_a : joy_b;

	// Run and select of the first pad ride along in the mouse byte
	assign pad0_run_select = joy_0[7:6];

	always_comb begin
		case (port)
			3'd0:    joy_sel = joy_0;
			3'd1:    joy_sel = joy_1;
			3'd2:    joy_sel = joy_2;
			3'd3:    joy_sel = joy_3;
			default: joy_sel = joy_4;
		endcase
	end

	always_comb begin
		if (port >= pce_pad_pkg::port_idx_t'(pce_pad_pkg::num_ports)) begin
			word = pce_pad_pkg::empty_word;
		end else if (port == 3'd0 && mouse_en) begin
			word.mouse = {mouse_byte, mouse_byte};  // Same byte either sel
		end else begin
			word = pad_view(joy_sel);
		end
	end

endmodule

/* hw/mouse_motion.sv */
// ========================================
// Mouse motion
// Captures deltas per strobe and serves
// them one nibble per clr frame
// ========================================

`timescale 1ns/1ps

module mouse_motion (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic [7:0]               mouse_x,
	input  logic [7:0]               mouse_y,
	input  logic                     mouse_strobe,
	input  logic [1:0]               mouse_buttons,  // bit 0 left, bit 1 right
	input  logic [1:0]               run_select,
	input  pce_pad_pkg::nibble_idx_t nib_cnt,
	input  logic                     frame_wrap,
	output logic [7:0]               mouse_byte
);

	logic [7:0] cap_x;  // Collected since last frame
	logic [7:0] cap_y;
	logic [7:0] ms_x;   // Served this frame
	logic [7:0] ms_y;

	// ========================================
	// Capture and frame handover
	// ========================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cap_x <= 8'h00;
			cap_y <= 8'h00;
			ms_x  <= 8'h00;
			ms_y  <= 8'h00;
		end else begin
			if (frame_wrap) begin
				ms_x  <= cap_x;
				ms_y  <= cap_y;
				cap_x <= 8'h00;
				cap_y <= 8'h00;
			end
			// A strobe on the wrap cycle starts the next frame's capture
			if (mouse_strobe) begin
				cap_x <= 8'd0 - mouse_x;  // Console counts x the other way
				cap_y <= mouse_y;
			end
		end
	end

	// ========================================
	// Byte for the current nibble
	// ========================================
	always_comb begin
		case (nib_cnt)
			2'd0:    mouse_byte[7:4] = ms_x[7:4];
			2'd1:    mouse_byte[7:4] = ms_x[3:0];
			2'd2:    mouse_byte[7:4] = ms_y[7:4];
			default: mouse_byte[7:4] = ms_y[3:0];
		endcase
	end

	// Buttons stay readable in every nibble
	assign mouse_byte[3:0] = ~{run_select, mouse_buttons[0], mouse_buttons[1]};

endmodule

/* hw/pad_nibble_latch.sv */
// ========================================
// Port nibble latch
// Registers the addressed nibble of the
// port word onto joy_in
// ========================================

`timescale 1ns/1ps

module pad_nibble_latch (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic [1:0]             joy_out,   // bit 0 sel, bit 1 clr
	input  logic                   high_bank,
	input  pce_pad_pkg::pad_word_u word,
	output logic [3:0]             joy_in
);

	logic [1:0] nib_sel;

	// Bank picks the upper pair, sel picks within it
	assign nib_sel = {high_bank, joy_out[0]};

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			joy_in <= 4'h0;
		end else if (joy_out[1]) begin
			joy_in <= 4'h0;  // Port reads blank during clr
		end else begin
			joy_in <= word.pad[nib_sel];
		end
	end

	// clr blanks the port on the following cycle
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		joy_out[1] |=> (joy_in == 4'h0))
		else $error("joy_in not blank after clr");

endmodule

/* hw/pad_input_top.sv */
// ========================================
// Controller port top level
// Pads, multitap and mouse onto the
// console's 4-bit nibble bus
// ========================================

`timescale 1ns/1ps

module pad_input_top #(
	parameter int mouse_timeout_w = 15
) (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic [pce_pad_pkg::joy_w-1:0] joy_a,
	input  logic [pce_pad_pkg::joy_w-1:0] joy_b,
	input  logic [pce_pad_pkg::joy_w-1:0] joy_2,
	input  logic [pce_pad_pkg::joy_w-1:0] joy_3,
	input  logic [pce_pad_pkg::joy_w-1:0] joy_4,
	input  logic                          joy_swap,
	input  logic                          turbotap,
	input  logic                          buttons6,
	input  logic                          mouse_en,
	input  logic [7:0]                    mouse_x,
	input  logic [7:0]                    mouse_y,
	input  logic [1:0]                    mouse_buttons,
	input  logic                          mouse_strobe,
	input  logic [1:0]                    joy_out,
	output logic [3:0]                    joy_in
);

	pce_pad_pkg::port_idx_t   port;
	pce_pad_pkg::nibble_idx_t nib_cnt;
	pce_pad_pkg::pad_word_u   word;
	logic                     high_bank;
	logic                     frame_wrap;
	logic [7:0]               mouse_byte;
	logic [1:0]               pad0_run_select;

	pad_port_ctrl #(.mouse_timeout_w(mouse_timeout_w)) u_ctrl (
		.clk_sys(clk_sys), .rst_n(rst_n), .joy_out(joy_out),
		.turbotap(turbotap), .buttons6(buttons6), .port(port),
		.high_bank(high_bank), .nib_cnt(nib_cnt), .frame_wrap(frame_wrap)
	);

	pad_word_mapper u_mapper (
		.joy_a(joy_a), .joy_b(joy_b), .joy_2(joy_2), .joy_3(joy_3), .joy_4(joy_4),
		.joy_swap(joy_swap), .mouse_en(mouse_en), .port(port),
		.mouse_byte(mouse_byte), .word(word), .pad0_run_select(pad0_run_select)
	);

	mouse_motion u_mouse (
		.clk_sys(clk_sys), .rst_n(rst_n), .mouse_x(mouse_x), .mouse_y(mouse_y),
		.mouse_strobe(mouse_strobe), .mouse_buttons(mouse_buttons),
		.run_select(pad0_run_select), .nib_cnt(nib_cnt),
		.frame_wrap(frame_wrap), .mouse_byte(mouse_byte)
	);

	pad_nibble_latch u_latch (
		.clk_sys(clk_sys), .rst_n(rst_n), .joy_out(joy_out),
		.high_bank(high_bank), .word(word), .joy_in(joy_in)
	);

endmodule

/* verification/tb_pad_checks.sv */
// ========================================
// Controller port reference model
// Tracks the port rules and checks joy_in
// ========================================

`timescale 1ns/1ps

module tb_pad_checks #(
	parameter int mouse_timeout_w = 6
) (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic [pce_pad_pkg::joy_w-1:0] joy_a, joy_b, joy_2, joy_3, joy_4,
	input  logic                          joy_swap, turbotap, buttons6, mouse_en,
	input  logic [7:0]                    mouse_x, mouse_y,
	input  logic [1:0]                    mouse_buttons,
	input  logic                          mouse_strobe,
	input  logic [1:0]                    joy_out,
	input  logic [3:0]                    joy_in,
	output logic                          check_failed,
	output logic [3:0]                    exp_nibble,
	output logic [3:0]                    got_nibble
);

	logic [1:0]                    m_prev;
	logic [2:0]                    m_port;
	logic                          m_bank;
	logic [1:0]                    m_nib;
	logic [mouse_timeout_w-1:0]    m_idle;
	logic [7:0]                    m_cap_x, m_cap_y, m_x, m_y;
	logic [3:0]                    m_joy_in;
	logic                          sel_edge, clr_edge, idle_full, wrap;
	logic [pce_pad_pkg::joy_w-1:0] cur_joy, first_pad;
	logic [3:0]                    delta, mouse_low, next_nibble;
	logic [1:0]                    idx;

	initial check_failed = 1'b0;

	// Active-low pad nibble; idx 3 is the unused one
	function automatic logic [3:0] pad_nibble(input logic [11:0] j, input logic [1:0] n);
		case (n)
			2'd0:    return ~j[7:4];
			2'd1:    return ~{j[1], j[2], j[0], j[3]};
			2'd2:    return ~j[11:8];
			default: return 4'h0;
		endcase
	endfunction

	task automatic flag_mismatch(input logic [3:0] expected, input logic [3:0] actual);
		exp_nibble   = expected;
		got_nibble   = actual;
		check_failed = 1'b1;
	endtask

	assign sel_edge  = joy_out[0] && !m_prev[0];
	assign clr_edge  = joy_out[1] && !m_prev[1];
	assign idle_full = (m_idle == {mouse_timeout_w{1'b1}});
	assign wrap      = clr_edge && (m_nib == 2'd3);

	always_comb begin
		first_pad = joy_swap ? joy_b : joy_a;
		case (m_port)
			3'd0:    cur_joy = first_pad;
			3'd1:    cur_joy = joy_swap ? joy_a : joy_b;
			3'd2:    cur_joy = joy_2;
			3'd3:    cur_joy = joy_3;
			default: cur_joy = joy_4;
		endcase
		case (m_nib)
			2'd0:    delta = m_x[7:4];
			2'd1:    delta = m_x[3:0];
			2'd2:    delta = m_y[7:4];
			default: delta = m_y[3:0];
		endcase
		mouse_low = {~first_pad[7], ~first_pad[6], ~mouse_buttons[0], ~mouse_buttons[1]};
		idx = {m_bank, joy_out[0]};
		if (m_port > 3'd4)
			next_nibble = (idx == 2'd3) ? 4'h0 : 4'hF;  // Empty port
		else if (m_port == 3'd0 && mouse_en)
			next_nibble = idx[0] ? delta : mouse_low;
		else
			next_nibble = pad_nibble(cur_joy, idx);
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			m_prev   <= 2'b00;
			m_port   <= 3'd0;
			m_bank   <= 1'b0;
			m_nib    <= 2'd3;
			m_idle   <= '0;
			{m_cap_x, m_cap_y, m_x, m_y} <= '0;
			m_joy_in <= 4'h0;
		end else begin
			m_prev <= joy_out;
			if (joy_out[1])
				m_port <= 3'd0;
			else if (sel_edge && turbotap)
				m_port <= m_port + 3'd1;
			if (clr_edge)
				m_bank <= buttons6 && !m_bank;
			if (joy_out[1])
				m_idle <= '0;
			else if (!idle_full)
				m_idle <= m_idle + 1'b1;
			if (clr_edge)
				m_nib <= m_nib + 2'd1;
			else if (idle_full)
				m_nib <= 2'd3;
			if (wrap) begin
				m_x <= m_cap_x;
				m_y <= m_cap_y;
			end
			if (mouse_strobe) begin
				m_cap_x <= ~mouse_x + 8'd1;  // x is negated
				m_cap_y <= mouse_y;
			end else if (wrap) begin
				m_cap_x <= 8'h00;
				m_cap_y <= 8'h00;
			end
			m_joy_in <= joy_out[1] ? 4'h0 : next_nibble;
		end
	end

	// ========================================
	// Checks on joy_in
	// ========================================
	assert property (@(posedge clk_sys) disable iff (!rst_n) joy_in == m_joy_in)
		else flag_mismatch($sampled(m_joy_in), $sampled(joy_in));

	assert property (@(posedge clk_sys) disable iff (!rst_n) joy_out[1] |=> joy_in == 4'h0)
		else flag_mismatch(4'h0, $sampled(joy_in));

	// Empty multitap port reads F in the low bank
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		(m_port > 3'd4 && !joy_out[1] && !m_bank) |=> joy_in == 4'hF)
		else flag_mismatch(4'hF, $sampled(joy_in));

endmodule

/* verification/tb_pad_input.sv */
// ========================================
// Controller port testbench
// Clock, reset, LFSR stimulus and watchdog
// ========================================

`timescale 1ns/1ps

module tb_pad_input;

	localparam int half_period = 50;
	localparam int timeout_w   = 6;
	localparam int hold        = 3;  // Cycles per strobe step
	localparam int idle_cycles = (1 << timeout_w) + 8;

	// Cycle budget per test, from the frames each one runs
	localparam int t1_cycles = 4 * 3 * hold;
	localparam int t2_cycles = 3 * 15 * hold;
	localparam int t3_cycles = 8 * 3 * hold;
	localparam int t4_cycles = 3 * 5 * hold;
	localparam int t5_cycles = 2 * idle_cycles + 3 + 10 * 3 * hold;
	localparam int watchdog_cycles = 8 + t1_cycles + t2_cycles + t3_cycles
		+ t4_cycles + t5_cycles + 100;

	logic                          clk_sys;
	logic                          rst_n;
	logic [pce_pad_pkg::joy_w-1:0] joy_a, joy_b, joy_2, joy_3, joy_4;
	logic                          joy_swap, turbotap, buttons6, mouse_en;
	logic [7:0]                    mouse_x, mouse_y;
	logic [1:0]                    mouse_buttons;
	logic                          mouse_strobe;
	logic [1:0]                    joy_out;  // bit 0 sel, bit 1 clr
	logic [3:0]                    joy_in;
	logic                          check_failed;
	logic [3:0]                    exp_nibble, got_nibble;
	logic [31:0]                   lfsr;
	string                         test_name;

	pad_input_top #(.mouse_timeout_w(timeout_w)) u_dut (.*);

	tb_pad_checks #(.mouse_timeout_w(timeout_w)) u_checks (.*);

	initial clk_sys = 1'b0;
	always #(half_period) clk_sys = ~clk_sys;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic randomize_pads();
		logic [31:0] r;
		r = rand_bits(24);
		joy_a = r[11:0];
		joy_b = r[23:12];
		r = rand_bits(24);
		joy_2 = r[11:0];
		joy_3 = r[23:12];
		r = rand_bits(14);
		joy_4         = r[11:0];
		mouse_buttons = r[13:12];
	endtask

	task automatic step(input logic [1:0] strobes);
		joy_out = strobes;
		repeat (hold) @(negedge clk_sys);
	endtask

	// clr with sel high, then sel low/high pairs
	task automatic run_frame(input int sel_pairs);
		randomize_pads();
		step(2'b11);
		repeat (sel_pairs) begin
			step(2'b00);
			step(2'b01);
		end
	endtask

	task automatic pulse_strobe();
		logic [31:0] r;
		r = rand_bits(16);
		mouse_x      = r[7:0];
		mouse_y      = r[15:8];
		mouse_strobe = 1'b1;
		@(negedge clk_sys);
		mouse_strobe = 1'b0;
	endtask

	task automatic wait_idle();
		joy_out = 2'b01;
		repeat (idle_cycles) @(negedge clk_sys);
	endtask

	// First failed check ends the run
	always @(posedge check_failed) begin
		$display("error: %s expected %h actual %h", test_name, exp_nibble, got_nibble);
		$display("TESTBENCH FAILED");
		$fatal(1, "joy_in did not match the port rules");
	end

	initial begin
		#(watchdog_cycles * 2 * half_period);
		$display("timeout: tests still running after %0d cycles", watchdog_cycles);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		lfsr = 32'h0c2cb8ef;
		test_name = "reset";
		{joy_a, joy_b, joy_2, joy_3, joy_4} = '0;
		{joy_swap, turbotap, buttons6, mouse_en} = 4'b0000;
		{mouse_x, mouse_y, mouse_buttons, mouse_strobe} = '0;
		joy_out = 2'b11;
		rst_n   = 1'b0;
		repeat (8) @(negedge clk_sys);
		rst_n = 1'b1;

		test_name = "single_pad";
		repeat (4) run_frame(1);

		test_name = "multitap_scan";
		turbotap = 1'b1;
		repeat (3) run_frame(7);

		test_name = "six_button";
		turbotap = 1'b0;
		buttons6 = 1'b1;
		repeat (6) run_frame(1);
		buttons6 = 1'b0;  // Bank falls back low
		repeat (2) run_frame(1);

		test_name = "joystick_swap";
		turbotap = 1'b1;
		joy_swap = 1'b1;
		repeat (3) run_frame(2);
		joy_swap = 1'b0;

		test_name = "mouse";
		turbotap = 1'b0;
		mouse_en = 1'b1;
		wait_idle();  // Next frame starts at x high
		pulse_strobe();
		repeat (4) run_frame(1);
		pulse_strobe();
		pulse_strobe();
		repeat (4) run_frame(1);
		wait_idle();
		repeat (2) run_frame(1);

		repeat (2) @(negedge clk_sys);
		if (check_failed) begin
			$display("TESTBENCH FAILED");
			$fatal(1, "check failed");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

/* verilog.f */
hw/pce_pad_pkg.sv
hw/pad_port_ctrl.sv
hw/pad_word_mapper.sv
hw/mouse_motion.sv
hw/pad_nibble_latch.sv
hw/pad_input_top.sv
verification/tb_pad_checks.sv
verification/tb_pad_input.sv

/* Bender.yml */
package:
  name: pce_pad_input

sources:
  - hw/pce_pad_pkg.sv
  - hw/pad_port_ctrl.sv
  - hw/pad_word_mapper.sv
  - hw/mouse_motion.sv
  - hw/pad_nibble_latch.sv
  - hw/pad_input_top.sv
  - target: test
    files:
      - verification/tb_pad_checks.sv
      - verification/tb_pad_input.sv
